// ==== include/hcring_macros.svh ====
// Build-time sizes for the host-to-device ring reader
// Shared by the package and by modules that need depths or intervals

`ifndef HCRING_MACROS_SVH
`define HCRING_MACROS_SVH

// Width of a ring index
// The ring holds 2**HCRING_IDX_BITS lines and wraps from the last line to the first
`define HCRING_IDX_BITS 8

// Width of one data line as returned by memory
`define HCRING_LINE_BITS 64

// Width of a line address on the memory request bus
`define HCRING_ADDR_BITS 32

// Number of reorder slots, which bounds the reads in flight
// Must be a power of two so the slot number fits the tag exactly
`define HCRING_SB_ENTRIES 16

// Consumed lines between periodic oldest-index reports to the host
`define HCRING_STATUS_INTERVAL 4

`endif

// ==== logic/hcring_pkg.sv ====
// Shared types of the host-to-device ring reader
// Index, address, line and reorder-tag types used across the design

`include "hcring_macros.svh"

package hcring_pkg;

    // ==============================
    // Ring and memory types
    // ==============================

    // Position inside the ring
    // Arithmetic on it wraps naturally because the ring is a power of two
    typedef logic [`HCRING_IDX_BITS-1:0] ring_idx_t;

    // Address of one line in host memory
    typedef logic [`HCRING_ADDR_BITS-1:0] line_addr_t;

    // One line of payload
    typedef logic [`HCRING_LINE_BITS-1:0] line_t;

    // ==============================
    // Reorder tag
    // ==============================

    // Bits needed to name one reorder slot
    localparam int SB_TAG_BITS = $clog2(`HCRING_SB_ENTRIES);

    // Reorder slot number
    // It travels with the read request and comes back on the response,
    // which is how an out-of-order answer finds its place
    typedef logic [SB_TAG_BITS-1:0] sb_tag_t;

endpackage

// ==== logic/hcring_mem_if.sv ====
// Memory read channel between the ring reader and the memory side
// Carries the held request with its grant and the tagged response strobe

interface hcring_mem_if;
    import hcring_pkg::*;

    // Request side
    // req, req_addr and req_tag stay stable until grant is seen with req
    logic       req;
    line_addr_t req_addr;
    sb_tag_t    req_tag;
    logic       grant;

    // Response side
    // One cycle strobe per granted tag, in any order and without back-pressure
    logic    rsp_valid;
    sb_tag_t rsp_tag;
    line_t   rsp_data;

    // The reader issues requests and takes responses
    modport reader (
        output req, req_addr, req_tag,
        input  grant,
        input  rsp_valid, rsp_tag, rsp_data
    );

    // The memory side grants requests and returns lines
    modport memory (
        input  req, req_addr, req_tag,
        output grant,
        output rsp_valid, rsp_tag, rsp_data
    );

endinterface

// ==== logic/fifo2.sv ====
// Two-entry FIFO with registered outputs
// Decouples a producer from a consumer that may stall

module fifo2 #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset_n,
    input  logic enq_en,
    input  T     enq_data,
    output logic not_full,
    output T     first,
    input  logic deq_en,
    output logic not_empty
);
    // Entry 0 is the head, entry 1 waits behind it
    logic valid0;
    logic valid1;
    T     data1;

    assign not_empty = valid0;
    assign not_full  = !valid1;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
        end
        else if (deq_en)
        begin
            // Second entry moves up, or a new entry goes straight to the head
            valid0 <= valid1 || enq_en;
            valid1 <= valid1 && enq_en;
        end
        else if (enq_en)
        begin
            valid0 <= 1'b1;
            valid1 <= valid0;
        end
    end

    // Head takes the waiting entry on a dequeue, else the incoming one when free
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            first <= valid1 ? data1 : enq_data;
        end
        else if (!valid0)
        begin
            first <= enq_data;
        end

        if (enq_en && (valid0 && !(deq_en && !valid1)))
        begin
            data1 <= enq_data;
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!reset_n)
        enq_en |-> not_full
    ) else $error("fifo2: enqueue while full");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!reset_n)
        deq_en |-> not_empty
    ) else $error("fifo2: dequeue while empty");

endmodule

// ==== logic/reorder_scoreboard.sv ====
// Reorder scoreboard for out-of-order memory responses
// Slots are allocated in order, filled by tag and drained in order

`include "hcring_macros.svh"

module reorder_scoreboard #(
    parameter type T         = logic,
    parameter int  N_ENTRIES = `HCRING_SB_ENTRIES
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                alloc_en,
    output logic                alloc_ready,
    output hcring_pkg::sb_tag_t alloc_tag,
    input  logic                fill_en,
    input  hcring_pkg::sb_tag_t fill_tag,
    input  T                    fill_data,
    input  logic                drain_en,
    output logic                head_valid,
    output T                    head_data
);
    import hcring_pkg::*;

    // Next slot to hand out and oldest slot still held
    sb_tag_t alloc_ptr;
    sb_tag_t drain_ptr;

    // Slot allocated to a request that has not drained yet
    logic [N_ENTRIES-1:0] allocated;
    // Response has landed in the slot
    logic [N_ENTRIES-1:0] filled;

    // Payload storage, written by tag and read at the drain pointer
    T slots [N_ENTRIES];

    // Step a slot pointer, wrapping at the last slot
    function automatic sb_tag_t next_slot(input sb_tag_t idx);
        if (idx == sb_tag_t'(N_ENTRIES - 1))
        begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    // ==============================
    // Allocation and drain
    // ==============================

    // The slot at the allocation pointer is free once its last user drained
    assign alloc_ready = !allocated[alloc_ptr];
    assign alloc_tag   = alloc_ptr;

    // Only a filled head may leave, which keeps the output in order
    assign head_valid = filled[drain_ptr];
    assign head_data  = slots[drain_ptr];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr <= '0;
            drain_ptr <= '0;
            allocated <= '0;
            filled    <= '0;
        end
        else
        begin
            // Allocate, fill and drain never touch the same slot in one
            // cycle, since each needs a different state of that slot
            if (alloc_en)
            begin
                allocated[alloc_ptr] <= 1'b1;
                alloc_ptr            <= next_slot(alloc_ptr);
            end

            if (fill_en)
            begin
                filled[fill_tag] <= 1'b1;
            end

            if (drain_en)
            begin
                allocated[drain_ptr] <= 1'b0;
                filled[drain_ptr]    <= 1'b0;
                drain_ptr            <= next_slot(drain_ptr);
            end
        end
    end

    // Response payload lands in whatever slot its tag names
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            slots[fill_tag] <= fill_data;
        end
    end

    // A response must answer an outstanding request exactly once
    a_fill_outstanding: assert property (
        @(posedge clk) disable iff (!reset_n)
        fill_en |-> (allocated[fill_tag] && !filled[fill_tag])
    ) else $error("reorder_scoreboard: fill of slot %0d not awaiting data", fill_tag);

    // The requester must honour alloc_ready
    a_alloc_not_full: assert property (
        @(posedge clk) disable iff (!reset_n)
        alloc_en |-> alloc_ready
    ) else $error("reorder_scoreboard: allocation while all slots are in use");

endmodule

// ==== logic/ring_status.sv ====
// Ring configuration registers and consumed-position reports
// Holds the host's base and newest index, and strobes the oldest index back

`include "hcring_macros.svh"

module ring_status (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   base_wr,
    input  hcring_pkg::line_addr_t base_addr_in,
    input  logic                   newest_wr,
    input  hcring_pkg::ring_idx_t  newest_in,
    output hcring_pkg::line_addr_t base_addr,
    output hcring_pkg::ring_idx_t  newest_idx,
    input  hcring_pkg::ring_idx_t  oldest_idx,
    output logic                   status_valid,
    output hcring_pkg::ring_idx_t  status_idx
);
    import hcring_pkg::*;

    // ==============================
    // Host configuration
    // ==============================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            base_addr  <= '0;
            newest_idx <= '0;
        end
        else
        begin
            if (base_wr)
            begin
                base_addr <= base_addr_in;
            end
            if (newest_wr)
            begin
                newest_idx <= newest_in;
            end
        end
    end

    // ==============================
    // Oldest-index reports
    // ==============================

    // Oldest index as last told to the host
    ring_idx_t last_idx;
    // Lines consumed since that report, modulo the ring size
    ring_idx_t pending;
    logic      report;

    assign pending = oldest_idx - last_idx;

    // Report every few lines, and also when the ring has drained so the host
    // sees every slot free without waiting for a full interval
    assign report = (pending >= ring_idx_t'(`HCRING_STATUS_INTERVAL)) ||
                    ((pending != '0) && (oldest_idx == newest_idx));

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            last_idx     <= '0;
            status_valid <= 1'b0;
            status_idx   <= '0;
        end
        else
        begin
            status_valid <= report;
            if (report)
            begin
                last_idx   <= oldest_idx;
                status_idx <= oldest_idx;
            end
        end
    end

endmodule

// ==== logic/ring_reader.sv ====
// Ring reader that fetches published lines from host memory
// Issues tagged reads, restores ring order and hands lines to the client

`include "hcring_macros.svh"

module ring_reader (
    input  logic                   clk,
    input  logic                   reset_n,
    hcring_mem_if.reader           mem,
    input  hcring_pkg::line_addr_t base_addr,
    input  hcring_pkg::ring_idx_t  newest_idx,
    output hcring_pkg::ring_idx_t  oldest_idx,
    output hcring_pkg::line_t      data,
    output logic                   data_valid,
    input  logic                   data_take
);
    import hcring_pkg::*;

    // Next ring position to request from memory
    ring_idx_t next_idx;

    // Scoreboard allocation and head signals
    logic    slot_ready;
    sb_tag_t slot_tag;
    logic    head_valid;
    line_t   head_data;

    // Output buffer state
    logic buf_not_full;
    logic drain_en;

    // ==============================
    // Memory read requests
    // ==============================

    // Request while the host has published lines we have not asked for and
    // a reorder slot is free to receive the answer
    assign mem.req = (next_idx != newest_idx) && slot_ready;

    // The index is added to the base rather than replacing its low bits,
    // so the ring only has to be a power of two in size, not aligned
    assign mem.req_addr = base_addr + line_addr_t'(next_idx);

    // The tag is the slot that the grant allocates
    assign mem.req_tag = slot_tag;

    // A grant moves on to the next ring line
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            next_idx <= '0;
        end
        else if (mem.grant)
        begin
            next_idx <= next_idx + 1'b1;
        end
    end

    // ==============================
    // Reordering and output
    // ==============================

    // Move the head line into the buffer as soon as it has arrived and
    // there is room for it
    assign drain_en = head_valid && buf_not_full;

    reorder_scoreboard #(
        .T         (line_t),
        .N_ENTRIES (`HCRING_SB_ENTRIES)
    ) u_scoreboard (
        .clk         (clk),
        .reset_n     (reset_n),
        .alloc_en    (mem.grant),
        .alloc_ready (slot_ready),
        .alloc_tag   (slot_tag),
        .fill_en     (mem.rsp_valid),
        .fill_tag    (mem.rsp_tag),
        .fill_data   (mem.rsp_data),
        .drain_en    (drain_en),
        .head_valid  (head_valid),
        .head_data   (head_data)
    );

    // Buffer toward the client so the scoreboard read stays off its path
    fifo2 #(
        .T (line_t)
    ) u_out_buf (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_en    (drain_en),
        .enq_data  (head_data),
        .not_full  (buf_not_full),
        .first     (data),
        .deq_en    (data_take && data_valid),
        .not_empty (data_valid)
    );

    // The oldest pointer moves as lines leave the scoreboard in ring order
    // The host may reuse every slot behind it
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest_idx <= '0;
        end
        else if (drain_en)
        begin
            oldest_idx <= oldest_idx + 1'b1;
        end
    end

    // The memory side may only grant what we are asking for
    a_grant_needs_req: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem.grant |-> mem.req
    ) else $error("ring_reader: memory grant without a request");

endmodule

// ==== logic/hcring_top.sv ====
// Top level of the host-to-device ring reader
// Joins the status registers and the reader, and exposes the memory channel

module hcring_top (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   base_wr,
    input  hcring_pkg::line_addr_t base_addr,
    input  logic                   newest_wr,
    input  hcring_pkg::ring_idx_t  newest_idx,
    output logic                   mem_req,
    output hcring_pkg::line_addr_t mem_req_addr,
    output hcring_pkg::sb_tag_t    mem_req_tag,
    input  logic                   mem_grant,
    input  logic                   mem_rsp_valid,
    input  hcring_pkg::sb_tag_t    mem_rsp_tag,
    input  hcring_pkg::line_t      mem_rsp_data,
    output hcring_pkg::line_t      data,
    output logic                   data_valid,
    input  logic                   data_take,
    output logic                   status_valid,
    output hcring_pkg::ring_idx_t  status_idx
);
    import hcring_pkg::*;

    // Registered ring configuration and the consumed position
    line_addr_t ring_base;
    ring_idx_t  ring_newest;
    ring_idx_t  ring_oldest;

    hcring_mem_if mem_if ();

    // Memory side of the channel goes out on plain ports
    assign mem_req          = mem_if.req;
    assign mem_req_addr     = mem_if.req_addr;
    assign mem_req_tag      = mem_if.req_tag;
    assign mem_if.grant     = mem_grant;
    assign mem_if.rsp_valid = mem_rsp_valid;
    assign mem_if.rsp_tag   = mem_rsp_tag;
    assign mem_if.rsp_data  = mem_rsp_data;

    ring_status u_status (
        .clk          (clk),
        .reset_n      (reset_n),
        .base_wr      (base_wr),
        .base_addr_in (base_addr),
        .newest_wr    (newest_wr),
        .newest_in    (newest_idx),
        .base_addr    (ring_base),
        .newest_idx   (ring_newest),
        .oldest_idx   (ring_oldest),
        .status_valid (status_valid),
        .status_idx   (status_idx)
    );

    ring_reader u_reader (
        .clk        (clk),
        .reset_n    (reset_n),
        .mem        (mem_if),
        .base_addr  (ring_base),
        .newest_idx (ring_newest),
        .oldest_idx (ring_oldest),
        .data       (data),
        .data_valid (data_valid),
        .data_take  (data_take)
    );

endmodule

// ==== verification/hcring_mem_model.sv ====
// Memory responder for the ring reader testbench
// Grants reads after random holds and answers them out of order

module hcring_mem_model #(
    parameter logic [15:0] SEED = 16'd42131
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   req,
    input  hcring_pkg::line_addr_t req_addr,
    input  hcring_pkg::sb_tag_t    req_tag,
    output logic                   grant,
    output logic                   rsp_valid,
    output hcring_pkg::sb_tag_t    rsp_tag,
    output hcring_pkg::line_t      rsp_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import hcring_pkg::*;

    logic [15:0] rng = SEED;
    int          cycle = 0;
    // Request that the current grant accepts, held past the rising edge
    line_addr_t  gnt_addr;
    sb_tag_t     gnt_tag;
    // Reads accepted but not yet answered, with the cycle each falls due
    line_addr_t  pend_addr[$];
    sb_tag_t     pend_tag[$];
    int          pend_due[$];

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step for every bit drawn
    task automatic draw_bits(input int n, output int value);
        value = 0;
        repeat (n)
        begin
            value = (value << 1) | rng[0];
            rng   = lfsr_step(rng);
        end
    endtask

    initial
    begin
        grant     = 1'b0;
        rsp_valid = 1'b0;
        rsp_tag   = '0;
        rsp_data  = '0;
    end

    // ==============================
    // Grant and respond
    // ==============================

    // Everything toward the DUT changes on the falling edge
    always @(negedge clk)
    begin : respond
        int delay;
        int hold;
        int pick;
        if (!reset_n)
        begin
            grant     <= 1'b0;
            rsp_valid <= 1'b0;
            pend_addr.delete();
            pend_tag.delete();
            pend_due.delete();
        end
        else
        begin
            cycle++;
            // A grant seen with req at the last rising edge was accepted
            if (grant)
            begin
                draw_bits(4, delay);
                pend_addr.push_back(gnt_addr);
                pend_tag.push_back(gnt_tag);
                pend_due.push_back(cycle + 1 + delay);
            end
            // Answer the first read that is due, so short delays overtake long ones
            pick = -1;
            foreach (pend_due[i])
            begin
                if (pick < 0 && pend_due[i] <= cycle)
                    pick = i;
            end
            rsp_valid <= (pick >= 0);
            if (pick >= 0)
            begin
                // Upper half is the address and lower half its inverse
                rsp_tag  <= pend_tag[pick];
                rsp_data <= line_t'({pend_addr[pick], ~pend_addr[pick]});
                pend_addr.delete(pick);
                pend_tag.delete(pick);
                pend_due.delete(pick);
            end
            // Withhold the grant about one cycle in four
            draw_bits(2, hold);
            grant    <= req && (hold != 0);
            gnt_addr <= req_addr;
            gnt_tag  <= req_tag;
        end
    end

endmodule

// ==== verification/hcring_tb.sv ====
// Testbench for the host-to-device ring reader
// Publishes lines, stalls the client and checks order, requests and status

`include "hcring_macros.svh"

module hcring_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import hcring_pkg::*;

    localparam int          CLK_PERIOD      = 100;
    localparam int          RING_LINES      = 1 << `HCRING_IDX_BITS;
    localparam int          TOTAL_LINES     = 300;
    localparam int          MAX_AHEAD       = `HCRING_SB_ENTRIES + 2;
    localparam int          WATCHDOG_CYCLES = 40 * TOTAL_LINES + 500;
    localparam logic [15:0] RNG_SEED        = 16'd42131;
    // Deliberately not aligned to the ring size
    localparam line_addr_t  RING_BASE       = line_addr_t'('h0001_2345);

    logic        clk = 1'b0;
    logic        reset_n = 1'b0;
    logic        base_wr = 1'b0;
    line_addr_t  base_addr = '0;
    logic        newest_wr = 1'b0;
    ring_idx_t   newest_idx = '0;
    logic        mem_req;
    line_addr_t  mem_req_addr;
    sb_tag_t     mem_req_tag;
    logic        mem_grant;
    logic        mem_rsp_valid;
    sb_tag_t     mem_rsp_tag;
    line_t       mem_rsp_data;
    line_t       data;
    logic        data_valid;
    logic        data_take = 1'b0;
    logic        status_valid;
    ring_idx_t   status_idx;

    // Progress of the test as seen from outside the DUT
    int          published = 0;
    int          grant_count = 0;
    int          taken_count = 0;
    int          stall_grants;
    int          errors = 0;
    int          failures = 0;
    ring_idx_t   last_status = '0;
    logic        take_enable = 1'b0;
    logic [15:0] rng = RNG_SEED;

    always #(CLK_PERIOD / 2) clk = ~clk;

    hcring_top uut (.*);

    hcring_mem_model #(
        .SEED (RNG_SEED)
    ) u_mem (
        .clk       (clk),
        .reset_n   (reset_n),
        .req       (mem_req),
        .req_addr  (mem_req_addr),
        .req_tag   (mem_req_tag),
        .grant     (mem_grant),
        .rsp_valid (mem_rsp_valid),
        .rsp_tag   (mem_rsp_tag),
        .rsp_data  (mem_rsp_data)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Address of the k-th line fetched, wrapping within the ring
    function automatic line_addr_t ring_line_addr(input int k);
        return RING_BASE + line_addr_t'(ring_idx_t'(k));
    endfunction

    // Reorder slots are handed out in order, so the k-th grant carries slot k
    function automatic sb_tag_t grant_slot(input int k);
        return sb_tag_t'(k % `HCRING_SB_ENTRIES);
    endfunction

    task automatic publish(input int count);
        @(negedge clk);
        newest_wr  = 1'b1;
        newest_idx = ring_idx_t'(count);
        published  = count;
        @(negedge clk);
        newest_wr = 1'b0;
    endtask

    // Client takes about three cycles in four while enabled
    always @(negedge clk)
    begin : drive_take
        logic [1:0] bits;
        for (int i = 0; i < 2; i++)
        begin
            bits[i] = rng[0];
            rng     = lfsr_step(rng);
        end
        data_take = take_enable && (bits != 2'b00);
    end

    // ==============================
    // Checks on the rising edge
    // ==============================

    always @(posedge clk)
    begin : check_outputs
        ring_idx_t step;
        if (reset_n)
        begin
            // Status is looked at before this edge's take is counted
            if (status_valid)
            begin
                step = status_idx - last_status;
                assert (step != 0 && step <= ring_idx_t'(RING_LINES / 2))
                else
                begin
                    errors++;
                    $display("error status order: expected after %0d, actual %0d",
                             last_status, status_idx);
                end
                step = status_idx - ring_idx_t'(taken_count);
                assert (step <= 2)
                else
                begin
                    errors++;
                    $display("error status range: expected %0d to %0d, actual %0d",
                             ring_idx_t'(taken_count), ring_idx_t'(taken_count + 2),
                             status_idx);
                end
                last_status = status_idx;
            end
            if (mem_req && mem_grant)
            begin
                assert (mem_req_addr == ring_line_addr(grant_count))
                else
                begin
                    errors++;
                    $display("error grant address: expected %h, actual %h",
                             ring_line_addr(grant_count), mem_req_addr);
                end
                assert (mem_req_tag == grant_slot(grant_count))
                else
                begin
                    errors++;
                    $display("error grant tag: expected %0d, actual %0d",
                             grant_slot(grant_count), mem_req_tag);
                end
                grant_count++;
            end
            if (data_valid && data_take)
            begin
                assert (data == {ring_line_addr(taken_count), ~ring_line_addr(taken_count)})
                else
                begin
                    errors++;
                    $display("error line order: expected %h, actual %h",
                             {ring_line_addr(taken_count), ~ring_line_addr(taken_count)}, data);
                end
                taken_count++;
            end
        end
    end

    a_idle_before_publish: assert property (
        @(posedge clk) disable iff (!reset_n)
        (published == 0) |-> !(mem_req || data_valid || status_valid)
    ) else
    begin
        failures++;
        $display("failure: DUT became active before any line was published");
    end

    a_no_req_past_published: assert property (
        @(posedge clk) disable iff (!reset_n)
        (grant_count == published) |-> !mem_req
    ) else
    begin
        failures++;
        $display("failure: request made after every published line was granted");
    end

    // Sixteen reorder slots plus the two buffered lines
    a_outstanding_bounded: assert property (
        @(posedge clk) disable iff (!reset_n)
        (grant_count - taken_count) <= MAX_AHEAD
    ) else
    begin
        failures++;
        $display("failure: more lines in flight than the slots and buffer can hold");
    end

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin : run_tests
        repeat (5) @(negedge clk);
        reset_n   <= 1'b1;
        base_wr   = 1'b1;
        base_addr = RING_BASE;
        @(negedge clk);
        base_wr = 1'b0;
        // Idle window for the check that nothing moves before publishing
        repeat (4) @(negedge clk);
        @(posedge clk);
        take_enable = 1'b1;
        publish(100);
        wait (taken_count == 100);
        // Stalled client fills the buffer and then every reorder slot
        @(posedge clk);
        take_enable = 1'b0;
        publish(200);
        wait (grant_count - taken_count == MAX_AHEAD);
        stall_grants = grant_count;
        repeat (20) @(negedge clk);
        assert (grant_count == stall_grants)
        else
        begin
            failures++;
            $display("failure: requests continued while the client was stalled");
        end
        // Releasing the client lets the ring wrap past its last line
        @(posedge clk);
        take_enable = 1'b1;
        publish(TOTAL_LINES);
        wait (taken_count == TOTAL_LINES);
        repeat (3) @(negedge clk);
        assert (last_status == ring_idx_t'(TOTAL_LINES))
        else
        begin
            errors++;
            $display("error final status: expected %0d, actual %0d",
                     ring_idx_t'(TOTAL_LINES), last_status);
        end
        $display("errors: %0d  failures: %0d", errors, failures);
        if (errors == 0 && failures == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Forty cycles for every line pushed, plus room for reset and stalls
    initial
    begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("failure: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== hcring.f ====
+incdir+include
logic/hcring_pkg.sv
logic/hcring_mem_if.sv
logic/fifo2.sv
logic/reorder_scoreboard.sv
logic/ring_status.sv
logic/ring_reader.sv
logic/hcring_top.sv
verification/hcring_mem_model.sv
verification/hcring_tb.sv

// ==== Bender.yml ====
package:
  name: hcring

export_include_dirs:
  - include

sources:
  - logic/hcring_pkg.sv
  - logic/hcring_mem_if.sv
  - logic/fifo2.sv
  - logic/reorder_scoreboard.sv
  - logic/ring_status.sv
  - logic/ring_reader.sv
  - logic/hcring_top.sv
  - target: simulation
    files:
      - verification/hcring_mem_model.sv
      - verification/hcring_tb.sv
